/* Bender.yml */
package:
  name: sdo_monitor

sources:
  - rtl/sdo_mon_pkg.sv
  - rtl/sdo_item_if.sv
  - rtl/sdo_request_decoder.sv
  - rtl/sdo_response_decoder.sv
  - rtl/sdo_verdict.sv
  - rtl/sdo_monitor_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_sdo_monitor.sv

/* build.f */
rtl/sdo_mon_pkg.sv
rtl/sdo_item_if.sv
rtl/sdo_request_decoder.sv
rtl/sdo_response_decoder.sv
rtl/sdo_verdict.sv
rtl/sdo_monitor_top.sv
verif/tb_clock_gen.sv
verif/tb_sdo_monitor.sv

/* rtl/sdo_item_if.sv */
// one decoded SDO item per cycle, valid is a single-cycle pulse with no ready
`timescale 1ns/10ps

interface sdo_item_if;

  logic                                   valid;
  sdo_mon_pkg::sdo_cmd_e                  cmd;
  logic [sdo_mon_pkg::index_w-1:0]        index;
  logic [sdo_mon_pkg::subindex_w-1:0]     subindex;
  // bytes 4..7 of the frame, little-endian
  logic [sdo_mon_pkg::payload_w/2-1:0]    data;

  modport decoder (
    output valid,
    output cmd,
    output index,
    output subindex,
    output data
  );

  modport verdict (
    input valid,
    input cmd,
    input index,
    input subindex,
    input data
  );

endinterface

/* rtl/sdo_mon_pkg.sv */
// expedited SDO only; data byte 0 of a frame is rx_data[63:56], multi-byte fields little-endian
package sdo_mon_pkg;

  // CAN frame fields
  localparam int cob_id_w   = 11;
  localparam int node_id_w  = 7;
  localparam int payload_w  = 64;
  localparam int index_w    = 16;
  localparam int subindex_w = 8;

  // result counters
  localparam int cnt_w = 16;

  // SDO COB-ID bases, node id is added on top
  localparam logic [cob_id_w-1:0] sdo_tx_base = 11'h600;
  localparam logic [cob_id_w-1:0] sdo_rx_base = 11'h580;

  // APB bus
  localparam int apb_addr_w = 8;
  localparam int apb_data_w = 32;

  // register map
  localparam logic [apb_addr_w-1:0] reg_ctrl       = 8'h00;
  localparam logic [apb_addr_w-1:0] reg_good       = 8'h04;
  localparam logic [apb_addr_w-1:0] reg_bad        = 8'h08;
  localparam logic [apb_addr_w-1:0] reg_abort      = 8'h0C;
  localparam logic [apb_addr_w-1:0] reg_abort_code = 8'h10;

  // decoded SDO command
  typedef enum logic [2:0] {
    cmd_upload_req,
    cmd_download_req,
    cmd_upload_rsp,
    cmd_download_rsp,
    cmd_abort,
    cmd_other
  } sdo_cmd_e;

  // verdict unit state
  typedef enum logic {
    st_idle,
    st_pending
  } verdict_state_e;

endpackage

/* rtl/sdo_monitor_top.sv */
// single CAN frame stream without back-pressure; verdict lands 2 cycles after a response frame
`timescale 1ns/10ps

module sdo_monitor_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rx_valid,
  input  logic [sdo_mon_pkg::cob_id_w-1:0]      rx_id,
  input  logic [sdo_mon_pkg::payload_w-1:0]     rx_data,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [sdo_mon_pkg::apb_addr_w-1:0]    paddr,
  input  logic [sdo_mon_pkg::apb_data_w-1:0]    pwdata,
  output logic [sdo_mon_pkg::apb_data_w-1:0]    prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic                                  mismatch_irq
);

  logic [sdo_mon_pkg::node_id_w-1:0] node_id;

  sdo_item_if req_item ();
  sdo_item_if rsp_item ();

  sdo_request_decoder u_req_dec (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .rx_id    (rx_id),
    .rx_data  (rx_data),
    .node_id  (node_id),
    .item     (req_item.decoder)
  );

  sdo_response_decoder u_rsp_dec (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .rx_id    (rx_id),
    .rx_data  (rx_data),
    .node_id  (node_id),
    .item     (rsp_item.decoder)
  );

  sdo_verdict u_verdict (
    .clk          (clk),
    .rst          (rst),
    .req          (req_item.verdict),
    .rsp          (rsp_item.verdict),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .node_id      (node_id),
    .mismatch_irq (mismatch_irq)
  );

endmodule

/* rtl/sdo_request_decoder.sv */
// client to server SDO frames for node_id; item valid follows the frame by one cycle
`timescale 1ns/10ps

module sdo_request_decoder (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                rx_valid,
  input  logic [sdo_mon_pkg::cob_id_w-1:0]    rx_id,
  input  logic [sdo_mon_pkg::payload_w-1:0]   rx_data,
  input  logic [sdo_mon_pkg::node_id_w-1:0]   node_id,
  sdo_item_if.decoder                         item
);

  logic [sdo_mon_pkg::cob_id_w-1:0] match_id;
  logic                             hit;
  logic [2:0]                       ccs;
  sdo_mon_pkg::sdo_cmd_e            cmd_next;

  assign match_id = sdo_mon_pkg::sdo_tx_base
                  + {{(sdo_mon_pkg::cob_id_w - sdo_mon_pkg::node_id_w){1'b0}}, node_id};
  assign hit = rx_valid && (rx_id == match_id);

  // client command specifier in the top bits of byte 0
  assign ccs = rx_data[63:61];

  always_comb
  begin
    case (ccs)
      3'd2:    cmd_next = sdo_mon_pkg::cmd_upload_req;
      // only expedited downloads are tracked
      3'd1:    cmd_next = rx_data[57] ? sdo_mon_pkg::cmd_download_req : sdo_mon_pkg::cmd_other;
      default: cmd_next = sdo_mon_pkg::cmd_other;
    endcase
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      item.valid <= 1'b0;
    else
      item.valid <= hit;
  end

  always_ff @(posedge clk)
  begin
    if (hit)
    begin
      item.cmd      <= cmd_next;
      item.index    <= {rx_data[47:40], rx_data[55:48]};
      item.subindex <= rx_data[39:32];
      item.data     <= {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};
    end
  end

  // a second request cannot follow directly behind the first
  a_req_single_pulse: assert property (
    @(posedge clk) disable iff (!rst) item.valid |=> !item.valid
  );

endmodule

/* rtl/sdo_response_decoder.sv */
// server to client SDO frames for node_id; abort code arrives in the data field
`timescale 1ns/10ps

module sdo_response_decoder (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                rx_valid,
  input  logic [sdo_mon_pkg::cob_id_w-1:0]    rx_id,
  input  logic [sdo_mon_pkg::payload_w-1:0]   rx_data,
  input  logic [sdo_mon_pkg::node_id_w-1:0]   node_id,
  sdo_item_if.decoder                         item
);

  logic [sdo_mon_pkg::cob_id_w-1:0] match_id;
  logic                             hit;
  logic [2:0]                       scs;
  sdo_mon_pkg::sdo_cmd_e            cmd_next;

  assign match_id = sdo_mon_pkg::sdo_rx_base
                  + {{(sdo_mon_pkg::cob_id_w - sdo_mon_pkg::node_id_w){1'b0}}, node_id};
  assign hit = rx_valid && (rx_id == match_id);

  // server command specifier
  assign scs = rx_data[63:61];

  always_comb
  begin
    case (scs)
      3'd2:    cmd_next = sdo_mon_pkg::cmd_upload_rsp;
      3'd3:    cmd_next = sdo_mon_pkg::cmd_download_rsp;
      3'd4:    cmd_next = sdo_mon_pkg::cmd_abort;
      default: cmd_next = sdo_mon_pkg::cmd_other;
    endcase
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      item.valid <= 1'b0;
    else
      item.valid <= hit;
  end

  // index and subindex echo the request, data is the value or the abort code
  always_ff @(posedge clk)
  begin
    if (hit)
    begin
      item.cmd      <= cmd_next;
      item.index    <= {rx_data[47:40], rx_data[55:48]};
      item.subindex <= rx_data[39:32];
      item.data     <= {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};
    end
  end

  // the verdict unit relies on a defined command with every item
  a_rsp_cmd_known: assert property (
    @(posedge clk) disable iff (!rst) item.valid |-> !$isunknown(item.cmd)
  );

endmodule

/* rtl/sdo_verdict.sv */
// one outstanding request at a time; counters saturate; APB has no wait states
`timescale 1ns/10ps

module sdo_verdict (
  input  logic                                  clk,
  input  logic                                  rst,
  sdo_item_if.verdict                           req,
  sdo_item_if.verdict                           rsp,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [sdo_mon_pkg::apb_addr_w-1:0]    paddr,
  input  logic [sdo_mon_pkg::apb_data_w-1:0]    pwdata,
  output logic [sdo_mon_pkg::apb_data_w-1:0]    prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic [sdo_mon_pkg::node_id_w-1:0]     node_id,
  output logic                                  mismatch_irq
);

  sdo_mon_pkg::verdict_state_e              state;
  sdo_mon_pkg::sdo_cmd_e                    pend_cmd;
  logic [sdo_mon_pkg::index_w-1:0]          pend_index;
  logic [sdo_mon_pkg::subindex_w-1:0]       pend_subindex;
  logic [sdo_mon_pkg::cnt_w-1:0]            good_cnt;
  logic [sdo_mon_pkg::cnt_w-1:0]            bad_cnt;
  logic [sdo_mon_pkg::cnt_w-1:0]            abort_cnt;
  logic [sdo_mon_pkg::payload_w/2-1:0]      abort_code;
  logic                                     enable;
  logic                                     apb_access;
  logic                                     ctrl_wr;
  logic                                     clear;
  logic                                     addr_mapped;
  logic                                     req_take;
  logic                                     rsp_match;

  assign apb_access = psel && penable;
  assign ctrl_wr    = apb_access && pwrite && (paddr == sdo_mon_pkg::reg_ctrl);
  assign clear      = ctrl_wr && pwdata[9];
  assign pready     = 1'b1;

  // only upload and expedited download requests open a transaction
  assign req_take = enable && req.valid
                 && (req.cmd == sdo_mon_pkg::cmd_upload_req
                  || req.cmd == sdo_mon_pkg::cmd_download_req);

  assign rsp_match = ((pend_cmd == sdo_mon_pkg::cmd_upload_req
                       && rsp.cmd == sdo_mon_pkg::cmd_upload_rsp)
                   || (pend_cmd == sdo_mon_pkg::cmd_download_req
                       && rsp.cmd == sdo_mon_pkg::cmd_download_rsp))
                  && (rsp.index == pend_index) && (rsp.subindex == pend_subindex);

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      node_id <= '0;
      enable  <= 1'b0;
    end
    else if (ctrl_wr)
    begin
      node_id <= pwdata[6:0];
      enable  <= pwdata[8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_take)
    begin
      pend_cmd      <= req.cmd;
      pend_index    <= req.index;
      pend_subindex <= req.subindex;
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      state        <= sdo_mon_pkg::st_idle;
      good_cnt     <= '0;
      bad_cnt      <= '0;
      abort_cnt    <= '0;
      abort_code   <= '0;
      mismatch_irq <= 1'b0;
    end
    else if (clear)
    begin
      state        <= sdo_mon_pkg::st_idle;
      good_cnt     <= '0;
      bad_cnt      <= '0;
      abort_cnt    <= '0;
      mismatch_irq <= 1'b0;
    end
    else
    begin
      mismatch_irq <= 1'b0;
      if (enable && rsp.valid)
      begin
        state <= sdo_mon_pkg::st_idle;
        if (state == sdo_mon_pkg::st_pending && rsp.cmd == sdo_mon_pkg::cmd_abort)
        begin
          abort_code <= rsp.data;
          if (abort_cnt != '1)
            abort_cnt <= abort_cnt + 1'b1;
        end
        else if (state == sdo_mon_pkg::st_pending && rsp_match)
        begin
          if (good_cnt != '1)
            good_cnt <= good_cnt + 1'b1;
        end
        else
        begin
          // wrong answer, or an answer nobody asked for
          mismatch_irq <= 1'b1;
          if (bad_cnt != '1)
            bad_cnt <= bad_cnt + 1'b1;
        end
      end
      // a new request replaces whatever was pending
      if (req_take)
        state <= sdo_mon_pkg::st_pending;
    end
  end

  // register read mux
  always_comb
  begin
    prdata      = '0;
    addr_mapped = 1'b1;
    case (paddr)
      sdo_mon_pkg::reg_ctrl:
      begin
        prdata[6:0] = node_id;
        prdata[8]   = enable;
      end
      sdo_mon_pkg::reg_good:       prdata[sdo_mon_pkg::cnt_w-1:0] = good_cnt;
      sdo_mon_pkg::reg_bad:        prdata[sdo_mon_pkg::cnt_w-1:0] = bad_cnt;
      sdo_mon_pkg::reg_abort:      prdata[sdo_mon_pkg::cnt_w-1:0] = abort_cnt;
      sdo_mon_pkg::reg_abort_code: prdata = abort_code;
      default:                     addr_mapped = 1'b0;
    endcase
  end

  // everything except ctrl is read-only
  assign pslverr = apb_access
                && (!addr_mapped || (pwrite && paddr != sdo_mon_pkg::reg_ctrl));

  a_irq_counts_bad: assert property (
    @(posedge clk) disable iff (!rst)
    mismatch_irq |-> (bad_cnt != $past(bad_cnt)) || (&bad_cnt)
  );

  // with no wait states the access phase is the single cycle after setup
  a_slverr_in_access: assert property (
    @(posedge clk) disable iff (!rst)
    pslverr |-> psel && penable && $past(psel && !penable)
  );

endmodule

/* verif/tb_clock_gen.sv */
// free-running 4 ns clock; reset is held low for the first 4 rising edges only
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  initial
  begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

/* verif/tb_sdo_monitor.sv */
// monitors node 0x2a only; mismatch_irq timing is checked at every falling edge against a model
`timescale 1ns/10ps

module tb_sdo_monitor;

  localparam logic [6:0]  node           = 7'h2a;
  localparam logic [10:0] req_id         = sdo_mon_pkg::sdo_tx_base + {4'd0, node};
  localparam logic [10:0] rsp_id         = sdo_mon_pkg::sdo_rx_base + {4'd0, node};
  localparam int          timeout_cycles = 50;

  logic        clk;
  logic        rst;
  logic        rx_valid;
  logic [10:0] rx_id;
  logic [63:0] rx_data;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        mismatch_irq;
  // frame on the bus is expected to be judged bad
  logic        bad_frame;
  logic        bad_d1;
  logic        bad_d2;
  logic [31:0] rng;
  int          errors;
  int          exp_good;
  int          exp_bad;
  int          exp_abort;

  tb_clock_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  sdo_monitor_top DUT (
    .clk          (clk),
    .rst          (rst),
    .rx_valid     (rx_valid),
    .rx_id        (rx_id),
    .rx_data      (rx_data),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .mismatch_irq (mismatch_irq)
  );

  // irq is due 2 cycles after the frame
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      bad_d1 <= 1'b0;
      bad_d2 <= 1'b0;
    end
    else
    begin
      bad_d1 <= rx_valid && bad_frame;
      bad_d2 <= bad_d1;
    end
  end

  always @(negedge clk)
  begin
    if (rst)
      assert (mismatch_irq === bad_d2)
      else report_value("mismatch_irq_timing", 32'(bad_d2), 32'(mismatch_irq));
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte 0 first, index and data little-endian
  function automatic logic [63:0] sdo_frame(input logic [7:0] cs_byte, input logic [15:0] index,
                                            input logic [7:0] subindex, input logic [31:0] data);
    return {cs_byte, index[7:0], index[15:8], subindex,
            data[7:0], data[15:8], data[23:16], data[31:24]};
  endfunction

  task automatic end_in_failure(input string what);
    errors++;
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    end_in_failure($sformatf("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else report_value(name, exp, act);
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (pready !== 1'b1)
    begin
      n++;
      if (n > timeout_cycles)
        end_in_failure("APB transfer never saw pready");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
    check_equal({name, "_pslverr"}, 32'h0, 32'(err));
    check_equal(name, exp, rdata);
  endtask

  task automatic write_ctrl(input logic [31:0] value);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, sdo_mon_pkg::reg_ctrl, value, rdata, err);
    check_equal("ctrl_write_pslverr", 32'h0, 32'(err));
  endtask

  task automatic check_counters(input string name);
    read_expect({name, "_good"}, sdo_mon_pkg::reg_good, exp_good);
    read_expect({name, "_bad"}, sdo_mon_pkg::reg_bad, exp_bad);
    read_expect({name, "_abort"}, sdo_mon_pkg::reg_abort, exp_abort);
  endtask

  task automatic send_frame(input logic [10:0] id, input logic [63:0] data, input logic bad);
    @(posedge clk);
    rx_valid  <= 1'b1;
    rx_id     <= id;
    rx_data   <= data;
    bad_frame <= bad;
    @(posedge clk);
    rx_valid  <= 1'b0;
    bad_frame <= 1'b0;
  endtask

  task automatic wait_for_state(input sdo_mon_pkg::verdict_state_e target);
    int n;
    n = 0;
    while (DUT.u_verdict.state != target)
    begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles)
        end_in_failure($sformatf("verdict unit never reached %s", target.name()));
    end
  endtask

  // request, then a response once the request is pending
  task automatic run_pair(input logic [7:0] req_cs, input logic [7:0] rsp_cs,
                          input logic [15:0] index, input logic [7:0] rsp_sub,
                          input logic [7:0] req_sub, input logic [31:0] data, input logic bad);
    send_frame(req_id, sdo_frame(req_cs, index, req_sub, data), 1'b0);
    wait_for_state(sdo_mon_pkg::st_pending);
    send_frame(rsp_id, sdo_frame(rsp_cs, index, rsp_sub, data), bad);
    wait_for_state(sdo_mon_pkg::st_idle);
    repeat (3) @(posedge clk);
  endtask

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    logic [15:0] idx;
    logic [7:0]  sub;
    logic [31:0] val;
    int          n;
    rx_valid  = 1'b0;
    rx_id     = '0;
    rx_data   = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    bad_frame = 1'b0;
    rng       = 32'hcd83;
    errors    = 0;
    exp_good  = 0;
    exp_bad   = 0;
    exp_abort = 0;
    n = 0;
    while (!rst)
    begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles)
        end_in_failure("reset was never released");
    end

    // reset values and APB error responses
    read_expect("reset_ctrl", sdo_mon_pkg::reg_ctrl, 32'h0);
    check_counters("reset");
    read_expect("reset_abort_code", sdo_mon_pkg::reg_abort_code, 32'h0);
    apb_transfer(1'b0, 8'h20, 32'h0, rdata, err);
    check_equal("unmapped_pslverr", 32'h1, 32'(err));
    apb_transfer(1'b1, sdo_mon_pkg::reg_good, 32'h5, rdata, err);
    check_equal("counter_write_pslverr", 32'h1, 32'(err));
    write_ctrl(32'h100 | node);
    read_expect("ctrl_readback", sdo_mon_pkg::reg_ctrl, 32'h100 | node);

    // good upload and expedited download pairs
    for (int i = 0; i < 6; i++)
    begin
      rng = xorshift32(rng);
      idx = rng[15:0];
      sub = rng[23:16];
      rng = xorshift32(rng);
      val = rng;
      if (rng[31])
        run_pair(8'h40, 8'h43, idx, sub, sub, val, 1'b0);
      else
        run_pair(8'h23, 8'h60, idx, sub, sub, val, 1'b0);
      exp_good++;
    end
    check_counters("good_pairs");

    // mismatches
    rng = xorshift32(rng);
    run_pair(8'h40, 8'h43, rng[15:0], rng[23:16] + 8'd1, rng[23:16], 32'h0, 1'b1);
    exp_bad++;
    check_counters("changed_subindex");
    rng = xorshift32(rng);
    run_pair(8'h40, 8'h60, rng[15:0], rng[23:16], rng[23:16], 32'h0, 1'b1);
    exp_bad++;
    check_counters("wrong_rsp_type");
    send_frame(rsp_id, sdo_frame(8'h43, 16'h1000, 8'h00, 32'h0), 1'b1);
    repeat (3) @(posedge clk);
    exp_bad++;
    check_counters("unsolicited_rsp");

    // abort with a random code
    rng = xorshift32(rng);
    idx = rng[15:0];
    sub = rng[23:16];
    rng = xorshift32(rng);
    run_pair(8'h40, 8'h80, idx, sub, sub, rng, 1'b0);
    exp_abort++;
    check_counters("abort");
    read_expect("abort_code", sdo_mon_pkg::reg_abort_code, rng);

    // frames for node 0x2b are not ours
    send_frame(req_id + 11'd1, sdo_frame(8'h40, 16'h2000, 8'h01, 32'h0), 1'b0);
    send_frame(rsp_id + 11'd1, sdo_frame(8'h60, 16'h2000, 8'h01, 32'h0), 1'b0);
    repeat (3) @(posedge clk);
    check_counters("other_node");

    // disabled monitor ignores everything
    write_ctrl({25'd0, node});
    send_frame(req_id, sdo_frame(8'h40, 16'h3000, 8'h02, 32'h0), 1'b0);
    send_frame(rsp_id, sdo_frame(8'h60, 16'h3000, 8'h02, 32'h0), 1'b0);
    repeat (3) @(posedge clk);
    check_counters("disabled");

    // clear bit self-clears
    write_ctrl(32'h300 | node);
    exp_good  = 0;
    exp_bad   = 0;
    exp_abort = 0;
    check_counters("cleared");
    read_expect("ctrl_after_clear", sdo_mon_pkg::reg_ctrl, 32'h100 | node);

    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
